/* move_cases.txt */
# Line 1: start board, 16 hex tiles in row major order
# Line 2: direction (8 left, 4 down, 2 up, 1 right), 16 expected tiles, changed won lost
000 000 000 000 002 000 000 000 000 000 000 000 004 000 008 000
4 002 000 008 000 004 000 000 000 000 000 000 000 000 000 000 000 1 0 0
000 002 000 010 000 000 000 000 000 004 000 000 000 000 000 000
2 000 000 000 000 000 000 000 000 000 002 000 000 000 004 000 010 1 0 0
002 000 004 000 000 000 000 000 000 000 000 000 008 000 000 000
8 000 000 002 004 000 000 000 000 000 000 000 000 000 000 000 008 1 0 0
000 000 000 000 000 000 002 004 000 000 000 020 000 000 000 000
1 000 000 000 000 002 004 000 000 020 000 000 000 000 000 000 000 1 0 0
000 000 000 002 002 000 000 002 002 000 000 000 004 000 000 000
4 008 000 000 004 000 000 000 000 000 000 000 000 000 000 000 000 1 0 0
000 000 002 000 000 000 002 000 000 000 002 000 000 000 002 000
2 000 000 000 000 000 000 000 000 000 000 000 000 000 000 008 000 1 0 0
000 000 000 000 000 000 000 000 004 004 008 000 000 000 000 000
8 000 000 000 000 000 000 000 000 000 000 000 010 000 000 000 000 1 0 0
002 002 004 008 000 000 000 000 000 000 000 000 002 004 008 010
1 010 000 000 000 000 000 000 000 000 000 000 000 002 004 008 010 1 0 0
002 004 008 010 004 008 010 020 000 000 000 000 000 000 000 000
4 002 004 008 010 004 008 010 020 000 000 000 000 000 000 000 000 0 0 0
400 000 000 000 400 000 000 000 000 000 000 000 000 000 000 000
4 800 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 1 1 0
002 004 002 004 004 002 004 002 002 004 002 004 004 002 004 002
1 002 004 002 004 004 002 004 002 002 004 002 004 004 002 004 002 0 0 1

/* files.f */
board_pkg.sv
move_pkg.sv
summation.sv
movement.sv
move_controller.sv
board_status.sv
game_core.sv
tb_clock.sv
game_core_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module game_core_tb -f files.f -o game_core_sim
	./obj_dir/game_core_sim | tee sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* game_core_tb.sv */
/*
	Game core testbench
	Checks reset, then loads boards from the case file, runs moves and checks
	board, changed, won and lost, then checks ignored moves, loads while busy
	and a reset in the middle of a move
*/
`timescale 1ns/1ns

module game_core_tb;

	import board_pkg::*;
	import move_pkg::*;

	localparam int max_cases = 32;
	localparam int directed_runs = 4;	// Reset, bad direction, load while busy, reset in a move

	logic clk;
	logic rst;
	logic load;
	logic move;
	logic [dir_width-1:0] direction;
	logic [tile_width-1:0] load_board [board_size][board_size];
	logic [tile_width-1:0] board [board_size][board_size];
	logic busy;
	logic done;
	logic changed;
	logic won;
	logic lost;

	logic [tile_width-1:0] start_tiles [max_cases][16];	// Row major
	logic [tile_width-1:0] expect_tiles [max_cases][16];
	logic [dir_width-1:0] case_dir [max_cases];
	logic [2:0] case_flags [max_cases];	// Changed, won, lost
	int num_cases;
	int mismatches;
	int failures;
	logic cases_read;
	string phase = "reset";	// Name of the running step for the timeout report

	tb_clock tb_clock_inst (.clk);

	game_core game_core_inst (
		.clk, .rst, .load, .move, .direction, .load_board,
		.board, .busy, .done, .changed, .won, .lost
	);

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("MISMATCH %s: got %h, expected %h", name, actual, expected);
			mismatches++;
		end
	endtask

	task automatic read_cases;
		int fd;
		int n;
		int v;
		string header;
		fd = $fopen("move_cases.txt", "r");
		if (fd == 0) begin
			$display("Could not open the case file move_cases.txt");
			failures++;
			return;
		end
		n = $fgets(header, fd);	// Two column description lines
		n = $fgets(header, fd);
		num_cases = 0;
		while (num_cases < max_cases && $fscanf(fd, " %h", v) == 1) begin
			start_tiles[num_cases][0] = tile_width'(v);
			for (int k = 1; k < 16; k++) begin
				n = $fscanf(fd, " %h", v);
				start_tiles[num_cases][k] = tile_width'(v);
			end
			n = $fscanf(fd, " %h", v);
			case_dir[num_cases] = dir_width'(v);
			for (int k = 0; k < 16; k++) begin
				n = $fscanf(fd, " %h", v);
				expect_tiles[num_cases][k] = tile_width'(v);
			end
			for (int k = 0; k < 3; k++) begin
				n = $fscanf(fd, " %h", v);
				case_flags[num_cases][2-k] = v[0];
			end
			num_cases++;
		end
		$fclose(fd);
	endtask

	// Load a case's start board, one idle cycle, then the move strobe
	task automatic start_move(input int idx, input logic [dir_width-1:0] dir);
		@(posedge clk);
		for (int r = 0; r < board_size; r++) begin
			for (int c = 0; c < board_size; c++) begin
				load_board[r][c] <= start_tiles[idx][r*board_size+c];
			end
		end
		load <= 1'b1;
		@(posedge clk);
		load <= 1'b0;
		@(posedge clk);
		move <= 1'b1;
		direction <= dir;
		@(negedge clk);	// Status of the loaded board is valid here
		if (!case_flags[idx][2]) begin	// Unchanged move keeps the flags
			check_value($sformatf("case %0d won after load", idx), won, case_flags[idx][1]);
			check_value($sformatf("case %0d lost after load", idx), lost, case_flags[idx][0]);
		end
		@(posedge clk);
		move <= 1'b0;
	endtask

	task automatic wait_done;
		do @(negedge clk); while (!done);	// Watchdog bounds this
	endtask

	task automatic run_case(input int idx);
		phase = $sformatf("case %0d", idx);
		start_move(idx, case_dir[idx]);
		wait_done();
		check_value($sformatf("case %0d changed", idx), changed, case_flags[idx][2]);
		for (int r = 0; r < board_size; r++) begin
			for (int c = 0; c < board_size; c++) begin
				check_value($sformatf("case %0d board[%0d][%0d]", idx, r, c),
					board[r][c], expect_tiles[idx][r*board_size+c]);
			end
		end
		@(negedge clk);	// Flags follow the stored board by one clock
		check_value($sformatf("case %0d won", idx), won, case_flags[idx][1]);
		check_value($sformatf("case %0d lost", idx), lost, case_flags[idx][0]);
	endtask

	task automatic check_reset;
		@(negedge clk);
		for (int r = 0; r < board_size; r++) begin
			for (int c = 0; c < board_size; c++) begin
				check_value($sformatf("reset board[%0d][%0d]", r, c), board[r][c], 0);
			end
		end
		check_value("reset busy", busy, 0);
		check_value("reset done", done, 0);
		check_value("reset changed", changed, 0);
		check_value("reset won", won, 0);
		check_value("reset lost", lost, 0);
	endtask

	task automatic check_bad_direction;
		logic seen;
		seen = 1'b0;
		phase = "non-one-hot move";
		start_move(0, 4'b0011);
		repeat (max_move_cycles) begin
			@(negedge clk);
			if (busy || done) seen = 1'b1;
		end
		if (seen) begin
			$display("A move with a non-one-hot direction was accepted");
			failures++;
		end
		for (int r = 0; r < board_size; r++) begin
			for (int c = 0; c < board_size; c++) begin
				check_value($sformatf("ignored move board[%0d][%0d]", r, c),
					board[r][c], start_tiles[0][r*board_size+c]);
			end
		end
	endtask

	// Column 0 of 2,2,4 falling down settles as a single 8
	task automatic check_load_while_busy;
		phase = "load while busy";
		@(posedge clk);
		for (int r = 0; r < board_size; r++) begin
			for (int c = 0; c < board_size; c++) begin
				load_board[r][c] <= tile_empty;
			end
		end
		load_board[1][0] <= 12'h002;
		load_board[2][0] <= 12'h002;
		load_board[3][0] <= 12'h004;
		load <= 1'b1;
		@(posedge clk);
		load <= 1'b0;
		move <= 1'b1;
		direction <= dir_down;
		@(posedge clk);
		move <= 1'b0;
		do @(negedge clk); while (!busy);
		@(posedge clk);
		for (int r = 0; r < board_size; r++) begin
			for (int c = 0; c < board_size; c++) begin
				load_board[r][c] <= 12'h002;	// Would fill the board if taken
			end
		end
		load <= 1'b1;	// Held over every busy cycle
		wait_done();
		for (int r = 0; r < board_size; r++) begin
			for (int c = 0; c < board_size; c++) begin
				check_value($sformatf("busy load board[%0d][%0d]", r, c), board[r][c],
					(r == 0 && c == 0) ? 8 : 0);
			end
		end
		@(posedge clk);
		load <= 1'b0;
	endtask

	// Reset while a move runs on a board holding a winning tile
	task automatic reset_during_move;
		phase = "reset during a move";
		@(posedge clk);
		for (int r = 0; r < board_size; r++) begin
			for (int c = 0; c < board_size; c++) begin
				load_board[r][c] <= 12'h002;
			end
		end
		load_board[0][0] <= tile_win;
		load <= 1'b1;
		@(posedge clk);
		load <= 1'b0;
		move <= 1'b1;
		direction <= dir_down;
		@(posedge clk);
		move <= 1'b0;
		do @(negedge clk); while (!busy);
		@(posedge clk);
		rst <= 1'b1;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		check_reset();
	endtask

	// Watchdog sized from the number of runs
	initial begin
		wait (cases_read);
		#((num_cases + directed_runs) * (max_move_cycles + 20) * 4);
		$display("Timeout: %s never finished", phase);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		rst = 1'b1;
		load = 1'b0;
		move = 1'b0;
		direction = '0;
		for (int r = 0; r < board_size; r++) begin
			for (int c = 0; c < board_size; c++) begin
				load_board[r][c] = tile_empty;
			end
		end
		mismatches = 0;
		failures = 0;
		cases_read = 1'b0;
		read_cases();
		cases_read = 1'b1;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		check_reset();
		if (num_cases == 0) begin
			$display("No cases were read from the case file");
			failures++;
		end else begin
			for (int idx = 0; idx < num_cases; idx++) run_case(idx);
			check_bad_direction();
			check_load_while_busy();
			reset_during_move();
		end
		$display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* tb_clock.sv */
/*
	Testbench clock
	Free running clock with a 4 ns period
*/
`timescale 1ns/1ns

module tb_clock (
	output logic clk
);

	initial clk = 1'b0;
	always #2 clk = ~clk;	// Half period

endmodule

/* game_core.sv */
/*
	Game core
	Move engine of the 4x4 tile game: board controller, merge pass,
	fall step and won/lost status
*/
`timescale 1ns/1ns

module game_core (
	input  logic clk,
	input  logic rst,
	input  logic load,
	input  logic move,
	input  logic [move_pkg::dir_width-1:0] direction,
	input  logic [board_pkg::tile_width-1:0] load_board
		[board_pkg::board_size][board_pkg::board_size],
	output logic [board_pkg::tile_width-1:0] board
		[board_pkg::board_size][board_pkg::board_size],
	output logic busy,
	output logic done,
	output logic changed,
	output logic won,
	output logic lost
);

	import board_pkg::*;
	import move_pkg::*;

	logic [tile_width-1:0] pass_board [board_size][board_size];
	logic [tile_width-1:0] summed_board [board_size][board_size];
	logic [tile_width-1:0] fall_in [board_size][board_size];
	logic [tile_width-1:0] fallen_board [board_size][board_size];
	logic [dir_width-1:0] move_dir;	// Direction latched for the move in progress
	logic ready;

	move_controller move_controller_inst (
		.clk, .rst, .load, .move, .direction, .load_board,
		.summed_board, .ready, .fallen_board,
		.board, .pass_board, .fall_in, .move_dir,
		.busy, .done, .changed
	);

	summation summation_inst (.clk, .move_dir, .pass_board, .summed_board, .ready);

	movement movement_inst (.clk, .move_dir, .fall_in, .fallen_board);

	board_status board_status_inst (.clk, .rst, .board, .won, .lost);

endmodule

/* board_status.sv */
/*
	Board status
	Registered won and lost flags of the held board
*/
`timescale 1ns/1ns

module board_status (
	input  logic clk,
	input  logic rst,
	input  logic [board_pkg::tile_width-1:0] board
		[board_pkg::board_size][board_pkg::board_size],
	output logic won,
	output logic lost
);

	import board_pkg::*;

	logic won_next;
	logic lost_next;

	always_comb begin
		won_next = 1'b0;
		lost_next = 1'b1;	// Until an empty cell or an equal pair shows up
		for (int i = 0; i < board_size; i++) begin
			for (int j = 0; j < board_size; j++) begin
				if (board[i][j] >= tile_win) won_next = 1'b1;
				if (board[i][j] == tile_empty) lost_next = 1'b0;
			end
		end
		for (int i = 0; i < board_size; i++) begin
			for (int j = 0; j < board_size-1; j++) begin
				if (board[i][j] == board[i][j+1]) lost_next = 1'b0;	// Pair in a row
				if (board[j][i] == board[j+1][i]) lost_next = 1'b0;	// Pair in a column
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			won <= 1'b0;
			lost <= 1'b0;
		end else begin
			won <= won_next;
			lost <= lost_next;
		end
	end

endmodule

/* move_controller.sv */
/*
	Move controller
	Holds the board, accepts loads and one-hot moves while idle, and runs
	merge and fall passes until the board settles. Pulses done with changed
*/
`timescale 1ns/1ns

module move_controller (
	input  logic clk,
	input  logic rst,
	input  logic load,
	input  logic move,
	input  logic [move_pkg::dir_width-1:0] direction,
	input  logic [board_pkg::tile_width-1:0] load_board
		[board_pkg::board_size][board_pkg::board_size],
	input  logic [board_pkg::tile_width-1:0] summed_board
		[board_pkg::board_size][board_pkg::board_size],
	input  logic ready,
	input  logic [board_pkg::tile_width-1:0] fallen_board
		[board_pkg::board_size][board_pkg::board_size],
	output logic [board_pkg::tile_width-1:0] board
		[board_pkg::board_size][board_pkg::board_size],
	output logic [board_pkg::tile_width-1:0] pass_board
		[board_pkg::board_size][board_pkg::board_size],
	output logic [board_pkg::tile_width-1:0] fall_in
		[board_pkg::board_size][board_pkg::board_size],
	output logic [move_pkg::dir_width-1:0] move_dir,
	output logic busy,
	output logic done,
	output logic changed
);

	import board_pkg::*;
	import move_pkg::*;

	move_state state;
	logic result_valid;	// Second cycle of a pass, registered result has arrived
	logic start;	// Move accepted this cycle
	logic differs;	// Merge result differs from the start board
	logic [tile_width-1:0] start_board [board_size][board_size];
	logic [5:0] busy_count;	// Length of the current move so far

	assign start = state == idle && !load && move && $onehot(direction);	// Load wins a tie
	assign pass_board = board;

	always_comb begin
		differs = 1'b0;
		for (int i = 0; i < board_size; i++) begin
			for (int j = 0; j < board_size; j++) begin
				if (summed_board[i][j] != start_board[i][j]) differs = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= idle;
			result_valid <= 1'b0;
			busy <= 1'b0;
			done <= 1'b0;
			changed <= 1'b0;
			for (int i = 0; i < board_size; i++) begin
				for (int j = 0; j < board_size; j++) begin
					board[i][j] <= tile_empty;
				end
			end
		end else begin
			done <= 1'b0;
			case (state)
				idle: begin
					if (load) begin
						board <= load_board;
					end else if (start) begin
						busy <= 1'b1;
						state <= sum;
					end
				end
				sum: begin
					result_valid <= !result_valid;
					if (result_valid && ready) begin
						board <= summed_board;	// Settled
						changed <= differs;
						done <= 1'b1;
						busy <= 1'b0;
						state <= idle;
					end else if (result_valid) begin
						state <= fall;
					end
				end
				fall: begin
					result_valid <= !result_valid;
					if (result_valid) begin
						board <= fallen_board;
						state <= sum;	// Next pass on the shifted board
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// Move data
	always_ff @(posedge clk) begin
		if (start) begin
			move_dir <= direction;
			start_board <= board;
		end
		if (state == sum && result_valid && !ready) fall_in <= summed_board;
	end

	always_ff @(posedge clk) begin
		if (rst || !busy) busy_count <= '0;
		else busy_count <= busy_count + 1'b1;
	end

	busy_bounded: assert property (@(posedge clk) disable iff (rst)
		busy_count < 6'(max_move_cycles));
	done_ends_busy: assert property (@(posedge clk) disable iff (rst) done |-> $past(busy));
	dir_onehot: assert property (@(posedge clk) disable iff (rst) busy |-> $onehot(move_dir));

endmodule

/* movement.sv */
/*
	Fall step
	Every tile with an empty cell on its move side shifts one cell toward
	that side, judged on the old board only. Result is registered
*/
`timescale 1ns/1ns

module movement (
	input  logic clk,
	input  logic [move_pkg::dir_width-1:0] move_dir,
	input  logic [board_pkg::tile_width-1:0] fall_in
		[board_pkg::board_size][board_pkg::board_size],
	output logic [board_pkg::tile_width-1:0] fallen_board
		[board_pkg::board_size][board_pkg::board_size]
);

	import board_pkg::*;
	import move_pkg::*;

	logic [tile_width-1:0] frame [board_size][board_size];	// Row 0 is the move side
	logic [tile_width-1:0] moved [board_size][board_size];	// Frame after one step
	logic [tile_width-1:0] unturned [board_size][board_size];
	logic [15:0] sum_in;	// Total of all tile values going in
	logic [15:0] sum_out;

	always_comb begin
		for (int i = 0; i < board_size; i++) begin
			for (int j = 0; j < board_size; j++) begin
				case (move_dir)
					dir_left:  frame[i][j] = fall_in[j][board_size-1-i];
					dir_up:    frame[i][j] = fall_in[board_size-1-i][j];
					dir_right: frame[i][j] = fall_in[board_size-1-j][i];
					default:   frame[i][j] = fall_in[i][j];
				endcase
			end
		end
	end

	// Decisions read frame, so a tile drops at most one cell
	always_comb begin
		moved = frame;
		for (int i = 1; i < board_size; i++) begin
			for (int j = 0; j < board_size; j++) begin
				if (frame[i][j] != tile_empty && frame[i-1][j] == tile_empty) begin
					moved[i-1][j] = frame[i][j];
					moved[i][j] = tile_empty;	// Vacated cell
				end
			end
		end
	end

	always_comb begin
		for (int i = 0; i < board_size; i++) begin
			for (int j = 0; j < board_size; j++) begin
				case (move_dir)
					dir_left:  unturned[i][j] = moved[board_size-1-j][i];
					dir_up:    unturned[i][j] = moved[board_size-1-i][j];
					dir_right: unturned[i][j] = moved[j][board_size-1-i];
					default:   unturned[i][j] = moved[i][j];
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		fallen_board <= unturned;
	end

	always_comb begin
		sum_in = '0;
		sum_out = '0;
		for (int i = 0; i < board_size; i++) begin
			for (int j = 0; j < board_size; j++) begin
				sum_in = sum_in + 16'(fall_in[i][j]);
				sum_out = sum_out + 16'(fallen_board[i][j]);
			end
		end
	end

	// A fall only relocates tiles
	tile_sum_kept: assert property (@(posedge clk) sum_out == $past(sum_in));

endmodule

/* summation.sv */
/*
	Merge pass
	Turns the board so the move side is row 0, merges equal pairs in scan
	order and flags whether any tile can still fall, then turns it back.
	Result and flag are registered once
*/
`timescale 1ns/1ns

module summation (
	input  logic clk,
	input  logic [move_pkg::dir_width-1:0] move_dir,
	input  logic [board_pkg::tile_width-1:0] pass_board
		[board_pkg::board_size][board_pkg::board_size],
	output logic [board_pkg::tile_width-1:0] summed_board
		[board_pkg::board_size][board_pkg::board_size],
	output logic ready
);

	import board_pkg::*;
	import move_pkg::*;

	logic [tile_width-1:0] frame [board_size][board_size];	// Row 0 is the move side
	logic [tile_width-1:0] merged [board_size][board_size];	// Frame after the scan
	logic [tile_width-1:0] unturned [board_size][board_size];	// Back in board order
	logic ready_next;	// No tile left with a gap below it
	logic [4:0] count_in;	// Occupied cells going in
	logic [4:0] count_out;	// Occupied cells coming out

	// Into the frame
	always_comb begin
		for (int i = 0; i < board_size; i++) begin
			for (int j = 0; j < board_size; j++) begin
				case (move_dir)
					dir_left:  frame[i][j] = pass_board[j][board_size-1-i];
					dir_up:    frame[i][j] = pass_board[board_size-1-i][j];
					dir_right: frame[i][j] = pass_board[board_size-1-j][i];
					default:   frame[i][j] = pass_board[i][j];	// Down is already the frame
				endcase
			end
		end
	end

	// Scan rows from the move side, later rows see earlier merges
	always_comb begin
		merged = frame;
		for (int i = 0; i < board_size-1; i++) begin
			for (int j = 0; j < board_size; j++) begin
				if (merged[i][j] != tile_empty && merged[i+1][j] == merged[i][j]) begin
					merged[i][j] = merged[i][j] << 1;	// Sum lands on the lower tile
					merged[i+1][j] = tile_empty;	// Partner is used up
				end
			end
		end
		ready_next = 1'b1;
		for (int i = 1; i < board_size; i++) begin
			for (int j = 0; j < board_size; j++) begin
				if (merged[i][j] != tile_empty && merged[i-1][j] == tile_empty) begin
					ready_next = 1'b0;	// Still room to fall
				end
			end
		end
	end

	// Out of the frame, inverse of the turn above
	always_comb begin
		for (int i = 0; i < board_size; i++) begin
			for (int j = 0; j < board_size; j++) begin
				case (move_dir)
					dir_left:  unturned[i][j] = merged[board_size-1-j][i];
					dir_up:    unturned[i][j] = merged[board_size-1-i][j];
					dir_right: unturned[i][j] = merged[j][board_size-1-i];
					default:   unturned[i][j] = merged[i][j];
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		summed_board <= unturned;
		ready <= ready_next;
	end

	// Occupancy on both sides of the register
	always_comb begin
		count_in = '0;
		count_out = '0;
		for (int i = 0; i < board_size; i++) begin
			for (int j = 0; j < board_size; j++) begin
				count_in = count_in + 5'(pass_board[i][j] != tile_empty);
				count_out = count_out + 5'(summed_board[i][j] != tile_empty);
			end
		end
	end

	// Merging only removes tiles, so a pass never adds one
	tile_count_no_rise: assert property (@(posedge clk) count_out <= $past(count_in));

endmodule

/* move_pkg.sv */
/*
	Move package
	One-hot direction codes, controller states and the busy bound of one move
*/
package move_pkg;

	localparam int dir_width = 4;	// One bit per direction

	// One-hot direction codes
	localparam logic [dir_width-1:0] dir_left  = 4'b1000;
	localparam logic [dir_width-1:0] dir_down  = 4'b0100;
	localparam logic [dir_width-1:0] dir_up    = 4'b0010;
	localparam logic [dir_width-1:0] dir_right = 4'b0001;

	// Controller states
	typedef enum logic [1:0] {
		idle,	// Waiting for a load or a move
		sum,	// Merge pass, then its decision
		fall	// One-cell fall step, then the store
	} move_state;

	// Worst case busy length of a move, with margin
	localparam int max_move_cycles = 40;

endpackage

/* board_pkg.sv */
/*
	Board package
	Geometry of the 4x4 board and the tile values that carry a fixed meaning
*/
package board_pkg;

	// Geometry
	localparam int board_size = 4;	// Tiles per side
	localparam int tile_width = 12;	// Bits per tile

	// Tile values
	localparam logic [tile_width-1:0] tile_empty = '0;	// Empty cell
	localparam logic [tile_width-1:0] tile_win = tile_width'(2048);	// Win threshold

endpackage
